/* Bender.yml */
package:
  name: heap_board

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/heap_pkg.sv
      - rtl/cell_bram.sv
      - rtl/cell_alloc.sv
      - rtl/step_sequencer.sv
      - rtl/heap_exerciser.sv
      - rtl/heap_board_top.sv
  - target: test
    include_dirs:
      - rtl
      - testbench
    files:
      - testbench/tb_heap_board.sv

/* rtl/cell_alloc.sv */
// free-list heap allocator
`timescale 1ns/1ps
`default_nettype none
`include "heap_defs.svh"

module cell_alloc #(
  parameter int ADDR_SZ = `HEAP_ADDR_SZ  // log2 of cell count
) (
  input  wire                       clk,
  input  wire                       rst_n,
  input  wire                       alloc,     // take a cell from the free list
  input  wire                       free,      // return addr_in to the free list
  input  wire                       rd,        // read cell addr_in
  input  wire                       wr,        // write data_in to cell addr_in
  input  wire heap_pkg::cell_t      data_in,
  input  wire heap_pkg::heap_addr_t addr_in,
  output heap_pkg::heap_addr_t      addr_out,  // allocated cell, nil on failure
  output wire heap_pkg::cell_t      rdata,     // read data, valid with done
  output logic                      done,      // one pulse per operation
  output logic                      ready,
  output logic                      err        // sticky
);

  import heap_pkg::*;

  localparam logic [ADDR_SZ-1:0] LAST_CELL = '1;

  alloc_state_t       state;
  logic [ADDR_SZ-1:0] init_cnt;  // cell being linked during init
  heap_addr_t         head;      // free list head, nil when empty
  cell_t              link_q;    // successor of the taken head
  cell_t              data_q;    // alloc data held while the link is read

  logic [ADDR_SZ-1:0] addr_idx;  // index part of addr_in
  logic               addr_ok;   // in range and not nil
  logic               any_req;

  // RAM ports
  logic               wr_en;
  logic [ADDR_SZ-1:0] waddr;
  cell_t              wdata;
  logic [ADDR_SZ-1:0] raddr;

  assign addr_idx = addr_in[ADDR_SZ-1:0];
  assign addr_ok  = ((addr_in >> ADDR_SZ) == '0) && (addr_idx != '0);
  assign any_req  = alloc | free | rd | wr;
  assign ready    = (state == idle);

  // alloc looks up the head link, rd looks up the user cell
  assign raddr = alloc ? head[ADDR_SZ-1:0] : addr_idx;

  // single write port shared by init, alloc, free and wr
  always_comb begin
    wr_en = 1'b0;
    waddr = head[ADDR_SZ-1:0];  // alloc_wr target
    wdata = data_q;
    case (state)
      init: begin
        wr_en = 1'b1;
        waddr = init_cnt;
        // cell i links to i+1, the last one ends the list
        if (init_cnt == LAST_CELL) begin
          wdata = `HEAP_NIL;
        end else begin
          wdata = cell_t'(init_cnt) + 1'b1;
        end
      end
      alloc_wr: begin
        wr_en = 1'b1;  // alloc data into the taken cell
      end
      idle: begin
        if (!alloc && free && addr_ok) begin
          // freed cell points at the old head, LIFO
          wr_en = 1'b1;
          waddr = addr_idx;
          wdata = cell_t'(head);
        end else if (!alloc && !free && wr && addr_ok) begin
          wr_en = 1'b1;
          waddr = addr_idx;
          wdata = data_in;
        end
      end
      default: begin
        wr_en = 1'b0;
      end
    endcase
  end

  // control FSM
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= init;
      init_cnt <= '0;
      head     <= `HEAP_NIL;
      addr_out <= `HEAP_NIL;
      done     <= 1'b0;
      err      <= 1'b0;
    end else begin
      done <= 1'b0;  // pulse only
      case (state)
        init: begin
          init_cnt <= init_cnt + 1'b1;
          if (init_cnt == LAST_CELL) begin
            state <= idle;
            head  <= heap_addr_t'(1);  // cell 1 heads the fresh list
          end
        end
        idle: begin
          if (alloc) begin
            if (head == `HEAP_NIL) begin
              // heap exhausted, answer nil right away
              done     <= 1'b1;
              addr_out <= `HEAP_NIL;
              err      <= 1'b1;
            end else begin
              state <= alloc_rd;
            end
          end else if (free || rd || wr) begin
            done <= 1'b1;
            if (!addr_ok) begin
              err <= 1'b1;  // nil or out of range
            end else if (free) begin
              head <= addr_in;
            end
          end
        end
        alloc_rd: begin
          // link arrives on rdata now, done lines up with the write
          state    <= alloc_wr;
          done     <= 1'b1;
          addr_out <= head;
        end
        alloc_wr: begin
          state <= idle;
          head  <= heap_addr_t'(link_q);  // pop
        end
        default: begin
          state <= init;
        end
      endcase
      if (any_req && !ready) begin
        err <= 1'b1;  // request while busy
      end
    end
  end

  // payload holding regs
  always_ff @(posedge clk) begin
    if (state == idle && alloc) begin
      data_q <= data_in;
    end
    if (state == alloc_rd) begin
      link_q <= rdata;
    end
  end

  cell_bram #(
    .ADDR_SZ(ADDR_SZ)
  ) bram0 (
    .clk  (clk),
    .wr_en(wr_en),
    .waddr(waddr),
    .wdata(wdata),
    .raddr(raddr),
    .rdata(rdata)
  );

endmodule

`default_nettype wire

/* rtl/cell_bram.sv */
// heap cell RAM
`timescale 1ns/1ps
`default_nettype none
`include "heap_defs.svh"

module cell_bram #(
  parameter int ADDR_SZ = `HEAP_ADDR_SZ  // log2 of depth
) (
  input  wire                  clk,
  input  wire                  wr_en,   // write strobe
  input  wire [ADDR_SZ-1:0]    waddr,
  input  wire heap_pkg::cell_t wdata,
  input  wire [ADDR_SZ-1:0]    raddr,
  output heap_pkg::cell_t      rdata    // valid one cycle after raddr
);

  import heap_pkg::*;

  localparam int DEPTH = 1 << ADDR_SZ;

  // inferred block RAM
  cell_t mem [DEPTH];

  // write port
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[waddr] <= wdata;
    end
  end

  // registered read port
  // same-address write returns the old word
  always_ff @(posedge clk) begin
    rdata <= mem[raddr];
  end

endmodule

`default_nettype wire

/* rtl/heap_board_top.sv */
// heap board exerciser top
`timescale 1ns/1ps
`default_nettype none
`include "heap_defs.svh"

module heap_board_top #(
  parameter int STEP_LOG2 = `STEP_LOG2,    // small in simulation
  parameter int ADDR_SZ   = `HEAP_ADDR_SZ
) (
  input  wire                       clk,
  input  wire                       rst_n,
  output wire                       led_r,
  output wire                       led_g,
  output wire                       led_b,
  output wire                       op_done,   // allocator done
  output wire heap_pkg::heap_addr_t op_addr,   // allocator addr_out
  output wire heap_pkg::cell_t      op_rdata   // allocator rdata
);

  import heap_pkg::*;

  // sequencer to exerciser
  logic       step;
  step_code_t code;

  // exerciser to allocator
  logic       alloc;
  logic       free;
  logic       rd;
  logic       wr;
  cell_t      data_in;
  heap_addr_t addr_in;

  // allocator status
  logic       ready;
  logic       err;

  step_sequencer #(
    .STEP_LOG2(STEP_LOG2)
  ) seq0 (
    .clk  (clk),
    .rst_n(rst_n),
    .step (step),
    .code (code)
  );

  heap_exerciser #(
    .ADDR_SZ(ADDR_SZ)
  ) exer0 (
    .clk     (clk),
    .rst_n   (rst_n),
    .step    (step),
    .code    (code),
    .ready   (ready),
    .done    (op_done),
    .addr_out(op_addr),
    .rdata   (op_rdata),
    .err     (err),
    .alloc   (alloc),
    .free    (free),
    .rd      (rd),
    .wr      (wr),
    .data_in (data_in),
    .addr_in (addr_in),
    .led_r   (led_r),
    .led_g   (led_g),
    .led_b   (led_b)
  );

  cell_alloc #(
    .ADDR_SZ(ADDR_SZ)
  ) alloc0 (
    .clk     (clk),
    .rst_n   (rst_n),
    .alloc   (alloc),
    .free    (free),
    .rd      (rd),
    .wr      (wr),
    .data_in (data_in),
    .addr_in (addr_in),
    .addr_out(op_addr),
    .rdata   (op_rdata),
    .done    (op_done),
    .ready   (ready),
    .err     (err)
  );

endmodule

`default_nettype wire

/* rtl/heap_defs.svh */
// heap exerciser defines
`ifndef HEAP_DEFS_SVH
`define HEAP_DEFS_SVH

// log2 of the cell count
// 16 cells, cell 0 is nil so 15 usable
`define HEAP_ADDR_SZ 4

// cell data width
`define CELL_W 16

// external address width, upper bits zero for valid cells
`define HEAP_ADDR_W 16

// log2 of cycles between step pulses
// roughly 22 ms at 48 MHz
`define STEP_LOG2 20

// undefined address
`define HEAP_NIL 16'h0000

`endif

/* rtl/heap_exerciser.sv */
// heap request generator and LED status
`timescale 1ns/1ps
`default_nettype none
`include "heap_defs.svh"

module heap_exerciser #(
  parameter int ADDR_SZ = `HEAP_ADDR_SZ  // log2 of held-cell ring depth
) (
  input  wire                       clk,
  input  wire                       rst_n,
  input  wire                       step,
  input  wire heap_pkg::step_code_t code,
  input  wire                       ready,
  input  wire                       done,
  input  wire heap_pkg::heap_addr_t addr_out,
  input  wire heap_pkg::cell_t      rdata,
  input  wire                       err,
  output logic                      alloc,
  output logic                      free,
  output logic                      rd,
  output logic                      wr,
  output heap_pkg::cell_t           data_in,
  output heap_pkg::heap_addr_t      addr_in,
  output logic                      led_r,  // allocator error
  output logic                      led_g,  // last read matched
  output logic                      led_b   // toggles per operation
);

  import heap_pkg::*;

  localparam int    DEPTH    = 1 << ADDR_SZ;
  localparam cell_t PAT_INIT = 5;
  localparam cell_t PAT_STEP = 13;

  // held cells, oldest at rd_ptr
  heap_addr_t         ring_addr [DEPTH];
  cell_t              ring_data [DEPTH];  // last data written per held cell
  logic [ADDR_SZ-1:0] rd_ptr;
  logic [ADDR_SZ-1:0] wr_ptr;
  logic [ADDR_SZ:0]   count;
  logic [ADDR_SZ-1:0] newest;

  cell_t              pat;       // data pattern
  cell_t              exp_data;  // copy of the value the pending read should return
  logic               pend_alloc;
  logic               pend_rd;

  logic               issue;
  logic               has_cell;
  logic               do_rd;
  logic               do_alloc;
  logic               do_wr;
  logic               do_free;
  logic               push;

  assign newest   = wr_ptr - 1'b1;
  assign has_cell = (count != '0);
  assign issue    = step && ready;

  // op decode from code[1:0], free needs code[3]
  assign do_rd    = issue && (code[1:0] == 2'b00) && has_cell;
  assign do_wr    = issue && (code[1:0] == 2'b10) && has_cell;
  assign do_free  = issue && (code[1:0] == 2'b11) && code[3] && has_cell;
  assign do_alloc = issue && ((code[1:0] == 2'b01) || ((code[1:0] == 2'b11) && !code[3]));

  // nil back from alloc means the heap was full
  assign push = done && pend_alloc && (addr_out != `HEAP_NIL);

  assign led_r = err;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      alloc      <= 1'b0;
      free       <= 1'b0;
      rd         <= 1'b0;
      wr         <= 1'b0;
      pat        <= PAT_INIT;
      rd_ptr     <= '0;
      wr_ptr     <= '0;
      count      <= '0;
      pend_alloc <= 1'b0;
      pend_rd    <= 1'b0;
      led_g      <= 1'b0;
      led_b      <= 1'b0;
    end else begin
      // strobes land in the cycle after step
      alloc <= do_alloc;
      free  <= do_free;
      rd    <= do_rd;
      wr    <= do_wr;
      if (do_alloc || do_wr) begin
        pat <= pat + PAT_STEP;
      end
      // push and pop never share a cycle
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
        count  <= count + 1'b1;
      end else if (do_free) begin
        rd_ptr <= rd_ptr + 1'b1;  // drop oldest
        count  <= count - 1'b1;
      end
      if (do_alloc) begin
        pend_alloc <= 1'b1;
      end else if (done) begin
        pend_alloc <= 1'b0;
      end
      if (do_rd) begin
        pend_rd <= 1'b1;
      end else if (done) begin
        pend_rd <= 1'b0;
      end
      if (done) begin
        led_b <= ~led_b;
      end
      if (done && pend_rd) begin
        led_g <= (rdata == exp_data);
      end
    end
  end

  // request payload and ring contents
  always_ff @(posedge clk) begin
    if (do_alloc || do_wr) begin
      data_in <= pat;
    end
    if (do_wr) begin
      addr_in           <= ring_addr[newest];
      ring_data[newest] <= pat;  // remember what was written
    end else if (do_rd || do_free) begin
      addr_in <= ring_addr[rd_ptr];
    end
    if (do_rd) begin
      exp_data <= ring_data[rd_ptr];
    end
    if (push) begin
      ring_addr[wr_ptr] <= addr_out;
      ring_data[wr_ptr] <= data_in;  // alloc data still on data_in
    end
  end

endmodule

`default_nettype wire

/* rtl/heap_pkg.sv */
// heap exerciser types
`default_nettype none
`include "heap_defs.svh"

package heap_pkg;

  // one word of cell content, also holds a free-list link
  typedef logic [`CELL_W-1:0] cell_t;

  // one cell address as seen on the request ports
  typedef logic [`HEAP_ADDR_W-1:0] heap_addr_t;

  // step number from the sequencer
  typedef logic [3:0] step_code_t;

  // allocator FSM
  typedef enum logic [1:0] {
    init,      // linking all cells into the free list
    idle,      // accepting requests
    alloc_rd,  // head link on the RAM read port
    alloc_wr   // data into taken cell, head advances
  } alloc_state_t;

endpackage

`default_nettype wire

/* rtl/step_sequencer.sv */
// step pulse sequencer
`timescale 1ns/1ps
`default_nettype none
`include "heap_defs.svh"

module step_sequencer #(
  parameter int STEP_LOG2 = `STEP_LOG2  // log2 of cycles per step
) (
  input  wire                  clk,
  input  wire                  rst_n,
  output logic                 step,  // one cycle per period
  output heap_pkg::step_code_t code   // step number, held between pulses
);

  // low bits time the step, top 4 bits number it
  logic [STEP_LOG2+3:0] cnt;
  logic                 at_step;

  // all ones in the low part
  assign at_step = &cnt[STEP_LOG2-1:0];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt  <= '0;
      step <= 1'b0;
      code <= '0;
    end else begin
      cnt  <= cnt + 1'b1;  // free running, wraps after 16 steps
      step <= at_step;
      if (at_step) begin
        code <= cnt[STEP_LOG2+3:STEP_LOG2];  // 0, 1 ... 15
      end
    end
  end

endmodule

`default_nettype wire

/* testbench/heap_ref_model.svh */
// heap exerciser reference model
`ifndef HEAP_REF_MODEL_SVH
`define HEAP_REF_MODEL_SVH

typedef enum int {op_read, op_alloc, op_write, op_free} op_kind_t;

localparam int    NUM_CELLS = 1 << `HEAP_ADDR_SZ;
localparam cell_t PAT_START = 16'd5;
localparam cell_t PAT_INC   = 16'd13;

// model state
heap_addr_t  held_addr [$];         // held cells, oldest first
cell_t       held_data [$];         // last data per held cell
heap_addr_t  free_list [$];         // front is the head
bit          was_freed [NUM_CELLS]; // cell has been freed at least once
cell_t       pattern;
int unsigned step_idx;              // next step pulse to replay
logic [15:0] lfsr_q;

// heap as it stands after init
function automatic void model_reset();
  int i;
  held_addr.delete();
  held_data.delete();
  free_list.delete();
  for (i = 1; i < NUM_CELLS; i++) begin
    free_list.push_back(heap_addr_t'(i));  // i links to i+1
    was_freed[i] = 1'b0;
  end
  pattern  = PAT_START;
  step_idx = 0;
  lfsr_q   = 16'd60565;
endfunction

// code of the n-th step pulse, cycles 0..15
function automatic step_code_t seq_code(input int unsigned n);
  return step_code_t'(n % 16);
endfunction

function automatic op_kind_t decode_code(input step_code_t c);
  case (c[1:0])
    2'b00: return op_read;
    2'b01: return op_alloc;
    2'b10: return op_write;
    default: begin
      if (c[3]) begin
        return op_free;
      end
      return op_alloc;
    end
  endcase
endfunction

// replay steps until one issues a request, then apply it
function automatic void model_next_op(output op_kind_t kind, output heap_addr_t exp_addr,
                                      output cell_t exp_data, output bit reused);
  bit issued;
  issued   = 1'b0;
  exp_addr = `HEAP_NIL;
  exp_data = '0;
  reused   = 1'b0;
  while (!issued) begin
    kind = decode_code(seq_code(step_idx));
    step_idx++;
    if (kind == op_alloc) begin
      issued   = 1'b1;  // alloc goes out even on a full heap
      exp_data = pattern;
      pattern  = pattern + PAT_INC;
      if (free_list.size() != 0) begin
        exp_addr = free_list.pop_front();
        reused   = was_freed[exp_addr[`HEAP_ADDR_SZ-1:0]];
        held_addr.push_back(exp_addr);
        held_data.push_back(exp_data);
      end
    end else if (held_addr.size() != 0) begin
      issued = 1'b1;  // empty ring skips read, write, free
      case (kind)
        op_read: exp_data = held_data[0];
        op_write: begin
          held_data[held_data.size()-1] = pattern;  // newest cell
          pattern = pattern + PAT_INC;
        end
        default: begin
          exp_addr = held_addr.pop_front();  // oldest goes back
          void'(held_data.pop_front());
          was_freed[exp_addr[`HEAP_ADDR_SZ-1:0]] = 1'b1;
          free_list.push_front(exp_addr);  // LIFO
        end
      endcase
    end
  end
endfunction

// 16-bit Galois LFSR, taps 16 14 13 11
function automatic logic [15:0] lfsr_next(input logic [15:0] s);
  if (s[0]) begin
    return (s >> 1) ^ 16'hB400;
  end
  return s >> 1;
endfunction

function automatic logic take_rand_bit();
  logic b;
  b      = lfsr_q[0];
  lfsr_q = lfsr_next(lfsr_q);  // one step per bit
  return b;
endfunction

`endif

/* testbench/tb_heap_board.sv */
// heap board testbench
`timescale 1ns/1ps
`default_nettype none
`include "heap_defs.svh"

module tb_heap_board;

  import heap_pkg::*;

  `include "heap_ref_model.svh"

  localparam int STEP_LOG2_SIM = 4;
  localparam int INIT_CYCLES   = 1 << `HEAP_ADDR_SZ;
  localparam int TARGET_DONES  = 18 * 15;  // about 17 step rounds
  // 20 rounds of 16 steps of 16 cycles plus init and a margin
  localparam int MAX_CYCLES = 20 * 16 * (1 << STEP_LOG2_SIM) + INIT_CYCLES + 256;

  logic       clk;
  logic       rst_n;
  logic       led_r;
  logic       led_g;
  logic       led_b;
  logic       op_done;
  heap_addr_t op_addr;
  cell_t      op_rdata;

  int unsigned cyc_total  = 0;
  int unsigned run_cycles = 0;  // cycles since reset release
  int unsigned n_dones    = 0;
  int unsigned n_nil      = 0;
  int unsigned n_reuse    = 0;
  int unsigned n_reads    = 0;
  logic        exp_err    = 1'b0;
  logic        exp_led_b  = 1'b0;
  logic        exp_led_g  = 1'b0;
  logic        led_g_due  = 1'b0;  // led_g check owed after a read done

  heap_board_top #(
    .STEP_LOG2(STEP_LOG2_SIM),
    .ADDR_SZ  (`HEAP_ADDR_SZ)
  ) dut0 (
    .clk     (clk),
    .rst_n   (rst_n),
    .led_r   (led_r),
    .led_g   (led_g),
    .led_b   (led_b),
    .op_done (op_done),
    .op_addr (op_addr),
    .op_rdata(op_rdata)
  );

  task automatic stop_with_failure();
    $display("** FAIL **");
    $fatal(1);
  endtask

  task automatic check_addr(input heap_addr_t got, input heap_addr_t exp, input string what);
    if (got !== exp) begin
      $display("error @%0t: %s got %h, expected %h", $time, what, got, exp);
      stop_with_failure();
    end
  endtask

  task automatic check_cell(input cell_t got, input cell_t exp, input string what);
    if (got !== exp) begin
      $display("error @%0t: %s got %h, expected %h", $time, what, got, exp);
      stop_with_failure();
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("error @%0t: %s got %b, expected %b", $time, what, got, exp);
      stop_with_failure();
    end
  endtask

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;  // 100 MHz
  end

  initial begin
    rst_n = 1'b0;
    model_reset();
    repeat (4) @(negedge clk);
    rst_n <= 1'b1;
    wait (n_dones >= TARGET_DONES);
    repeat (2) @(posedge clk);  // let the last led_g check land
    if (n_nil > 0 && n_reuse > 0 && n_reads > 0) begin
      $display("** PASS **");
      $finish;
    end else begin
      $display("run ended without a full heap, a reused cell and a read (%0d %0d %0d)",
               n_nil, n_reuse, n_reads);
      stop_with_failure();
    end
  end

  // compare at mid-cycle where outputs are settled
  always @(negedge clk) begin
    op_kind_t   kind;
    heap_addr_t exp_addr;
    cell_t      exp_data;
    bit         reused;
    logic       pick;
    if (rst_n !== 1'b1) begin
      check_bit(op_done, 1'b0, "op_done in reset");
      check_bit(led_r, 1'b0, "led_r in reset");
      check_bit(led_g, 1'b0, "led_g in reset");
      check_bit(led_b, 1'b0, "led_b in reset");
    end else begin
      run_cycles++;
      if (led_g_due) begin
        check_bit(led_g, 1'b1, "led_g after read");
        exp_led_g = 1'b1;
        led_g_due = 1'b0;
      end else begin
        pick = take_rand_bit();
        pick = pick & take_rand_bit();  // roughly one cycle in four
        if (pick) begin
          check_bit(led_g, exp_led_g, "led_g sample");
        end
      end
      if (op_done !== 1'b0 && op_done !== 1'b1) begin
        $display("op_done is unknown at time %0t", $time);
        stop_with_failure();
      end
      check_bit(led_b, exp_led_b, "led_b");  // toggles a cycle after done
      if (op_done) begin
        if (run_cycles <= INIT_CYCLES) begin
          $display("op_done came at time %0t while the allocator was still in init", $time);
          stop_with_failure();
        end
        model_next_op(kind, exp_addr, exp_data, reused);
        n_dones++;
        exp_led_b = ~exp_led_b;
        case (kind)
          op_alloc: begin
            check_addr(op_addr, exp_addr, "alloc address");
            if (exp_addr == `HEAP_NIL) begin
              exp_err = 1'b1;  // heap full and sticky
              n_nil++;
            end
            if (reused) begin
              n_reuse++;
            end
          end
          op_read: begin
            check_cell(op_rdata, exp_data, "read data");
            led_g_due = 1'b1;
            n_reads++;
          end
          default: begin
            // write and free only pulse done
          end
        endcase
      end
      check_bit(led_r, exp_err, "led_r");
    end
  end

  // watchdog
  always @(posedge clk) begin
    cyc_total++;
    if (cyc_total >= MAX_CYCLES) begin
      $display("timeout after %0d cycles with %0d of %0d operations done",
               cyc_total, n_dones, TARGET_DONES);
      stop_with_failure();
    end
  end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+rtl
+incdir+testbench
rtl/heap_pkg.sv
rtl/cell_bram.sv
rtl/cell_alloc.sv
rtl/step_sequencer.sv
rtl/heap_exerciser.sv
rtl/heap_board_top.sv
testbench/tb_heap_board.sv
